// ==== Makefile ====
.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"

test:
	verilator --binary --timing --assert --timescale 1ns/1ps \
		-f redmule.f --top-module redmule_tb -Mdir obj_dir
	@out="$$(./obj_dir/Vredmule_tb)"; \
	echo "$$out"; \
	echo "$$out" | grep -q "^Result: PASSED$$"

clean:
	rm -rf obj_dir

// ==== redmule.f ====
+incdir+source
source/redmule_pkg.sv
source/redmule_stream_fifo.sv
source/redmule_engine.sv
source/redmule_scheduler.sv
source/redmule_ctrl.sv
source/redmule_lockstep_checker.sv
source/redmule_top.sv
tests/redmule_tb.sv

// ==== source/redmule_ctrl.sv ====
// Register port and job control
`timescale 1ns/1ps
`default_nettype none

`include "redmule_defs.svh"

module redmule_ctrl (
  input  logic                     clk_i,
  input  logic                     reset_i,
  input  redmule_pkg::periph_req_t periph_req_i,
  output redmule_pkg::periph_rsp_t periph_rsp_o,
  input  logic                     done_i,
  input  logic                     fault_i,
  output logic                     start_o,
  output redmule_pkg::k_cnt_t      k_o,
  output logic                     busy_o,
  output logic                     evt_o
);

  import redmule_pkg::*;

  reg_addr_e   addr;
  k_cnt_t      k_q;
  k_cnt_t      k_wr;
  logic        busy_q;
  logic        evt_q;
  logic        wr;
  logic        rd;
  logic        r_valid_q;
  logic [31:0] r_data_q;
  logic [31:0] r_data_d;

  assign addr = reg_addr_e'(periph_req_i.addr);
  assign wr   = periph_req_i.req && periph_req_i.wen;
  assign rd   = periph_req_i.req && !periph_req_i.wen;
  assign k_wr = k_cnt_t'(periph_req_i.wdata);

  // Trigger while busy is dropped
  assign start_o = wr && (addr == REG_TRIGGER) && !busy_q;

  always_comb begin
    case (addr)
      REG_K:      r_data_d = {{(32 - `REDMULE_K_W){1'b0}}, k_q};
      REG_STATUS: r_data_d = {30'b0, fault_i, busy_q};
      default:    r_data_d = '0;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      k_q       <= k_cnt_t'(1);
      busy_q    <= 1'b0;
      evt_q     <= 1'b0;
      r_valid_q <= 1'b0;
    end else begin
      // Zero steps makes no job, keep at least one
      if (wr && addr == REG_K) k_q <= (k_wr == '0) ? k_cnt_t'(1) : k_wr;
      if (start_o) begin
        busy_q <= 1'b1;
      end else if (done_i) begin
        busy_q <= 1'b0;
      end
      evt_q     <= done_i;
      r_valid_q <= rd;
    end
  end

  always_ff @(posedge clk_i) begin
    if (rd) r_data_q <= r_data_d;
  end

  assign periph_rsp_o.gnt     = periph_req_i.req;
  assign periph_rsp_o.r_valid = r_valid_q;
  assign periph_rsp_o.r_data  = r_data_q;

  assign k_o    = k_q;
  assign busy_o = busy_q;
  assign evt_o  = evt_q;

  assert property (@(posedge clk_i) disable iff (reset_i) start_o |-> !busy_o ##1 busy_o)
    else $error("start issued while busy");

endmodule

`default_nettype wire

// ==== source/redmule_defs.svh ====
// Matrix engine size macros
`ifndef REDMULE_DEFS_SVH
`define REDMULE_DEFS_SVH

// Element and accumulator widths
`define REDMULE_ELEM_W 8
`define REDMULE_ACC_W 32

// Array shape: w beat and z row width, x beat width and z row count
`define REDMULE_ARRAY_H 4
`define REDMULE_ARRAY_W 4

// Step count width, K runs from 1 to 255
`define REDMULE_K_W 8

// Stream FIFO depths
`define REDMULE_IN_DEPTH 4
`define REDMULE_OUT_DEPTH 2

// Register port address width
`define REDMULE_ADDR_W 4

`endif

// ==== source/redmule_engine.sv ====
// Integer outer-product accumulator array
`timescale 1ns/1ps
`default_nettype none

`include "redmule_defs.svh"

module redmule_engine (
  input  logic                  clk_i,
  input  logic                  reset_i,
  input  logic                  step_i,
  input  logic                  clear_i,
  input  redmule_pkg::x_vec_t   x_i,
  input  redmule_pkg::w_vec_t   w_i,
  input  redmule_pkg::row_idx_t row_sel_i,
  output redmule_pkg::z_row_t   z_row_o
);

  import redmule_pkg::*;

  z_row_t [`REDMULE_ARRAY_W-1:0] acc_q;
  z_row_t [`REDMULE_ARRAY_W-1:0] prod;

  // Outer product of the current x column and w row
  always_comb begin
    for (int i = 0; i < `REDMULE_ARRAY_W; i++) begin
      for (int j = 0; j < `REDMULE_ARRAY_H; j++) begin
        prod[i][j] = acc_t'($signed(x_i[i])) * acc_t'($signed(w_i[j]));
      end
    end
  end

  // Clear wins over step
  always_ff @(posedge clk_i) begin
    if (reset_i || clear_i) begin
      acc_q <= '0;
    end else if (step_i) begin
      for (int i = 0; i < `REDMULE_ARRAY_W; i++) begin
        for (int j = 0; j < `REDMULE_ARRAY_H; j++) begin
          acc_q[i][j] <= acc_q[i][j] + prod[i][j];
        end
      end
    end
  end

  // Selected row goes straight to the z FIFO
  assign z_row_o = acc_q[row_sel_i];

endmodule

`default_nettype wire

// ==== source/redmule_lockstep_checker.sv ====
// Scheduler lockstep comparator
`timescale 1ns/1ps
`default_nettype none

module redmule_lockstep_checker (
  input  logic                     clk_i,
  input  logic                     reset_i,
  input  redmule_pkg::sched_ctrl_t main_i,
  input  redmule_pkg::sched_ctrl_t replica_i,
  output logic                     fault_o
);

  logic mismatch;
  logic fault_q;

  // Any differing field counts
  assign mismatch = (main_i != replica_i);

  // Sticky until reset
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      fault_q <= 1'b0;
    end else if (mismatch) begin
      fault_q <= 1'b1;
    end
  end

  assign fault_o = fault_q;

endmodule

`default_nettype wire

// ==== source/redmule_pkg.sv ====
// Matrix engine shared types
`default_nettype none

`include "redmule_defs.svh"

package redmule_pkg;

  // Datapath elements
  typedef logic signed [`REDMULE_ELEM_W-1:0] elem_t;
  typedef logic signed [`REDMULE_ACC_W-1:0] acc_t;

  // One x column, one w row, one z row
  typedef elem_t [`REDMULE_ARRAY_W-1:0] x_vec_t;
  typedef elem_t [`REDMULE_ARRAY_H-1:0] w_vec_t;
  typedef acc_t [`REDMULE_ARRAY_H-1:0] z_row_t;

  typedef logic [$clog2(`REDMULE_ARRAY_W)-1:0] row_idx_t;
  typedef logic [`REDMULE_K_W-1:0] k_cnt_t;

  // Register map
  typedef enum logic [`REDMULE_ADDR_W-1:0] {
    REG_K       = 'd0,
    REG_TRIGGER = 'd1,
    REG_STATUS  = 'd2
  } reg_addr_e;

  typedef enum logic [1:0] {
    S_IDLE,
    S_STREAM,
    S_DRAIN
  } sched_state_e;

  // Periph port, wen high means write
  typedef struct packed {
    logic                       req;
    logic                       wen;
    logic [`REDMULE_ADDR_W-1:0] addr;
    logic [31:0]                wdata;
  } periph_req_t;

  typedef struct packed {
    logic        gnt;
    logic        r_valid;
    logic [31:0] r_data;
  } periph_rsp_t;

  // Everything one scheduler replica drives
  typedef struct packed {
    logic     x_ready;
    logic     w_ready;
    logic     step;
    logic     clear_acc;
    logic     z_valid;
    row_idx_t z_row;
    logic     done;
  } sched_ctrl_t;

endpackage

`default_nettype wire

// ==== source/redmule_scheduler.sv ====
// Job sequencing FSM
`timescale 1ns/1ps
`default_nettype none

`include "redmule_defs.svh"

module redmule_scheduler (
  input  logic                     clk_i,
  input  logic                     reset_i,
  input  logic                     start_i,
  input  redmule_pkg::k_cnt_t      k_i,
  input  logic                     x_valid_i,
  input  logic                     w_valid_i,
  input  logic                     z_ready_i,
  output redmule_pkg::sched_ctrl_t ctrl_o
);

  import redmule_pkg::*;

  localparam row_idx_t LAST_ROW = row_idx_t'(`REDMULE_ARRAY_W - 1);

  sched_state_e state_q;
  sched_state_e state_d;
  k_cnt_t       k_q;
  k_cnt_t       step_cnt_q;
  row_idx_t     row_q;
  logic         launch;
  logic         step;
  logic         push;
  logic         last_step;
  logic         last_row;

  assign launch    = (state_q == S_IDLE) && start_i;
  // One step per cycle where both input heads are present
  assign step      = (state_q == S_STREAM) && x_valid_i && w_valid_i;
  assign push      = (state_q == S_DRAIN) && z_ready_i;
  assign last_step = (step_cnt_q == k_q - k_cnt_t'(1));
  assign last_row  = (row_q == LAST_ROW);

  always_comb begin
    state_d = state_q;
    case (state_q)
      S_IDLE: begin
        if (start_i) state_d = S_STREAM;
      end
      S_STREAM: begin
        if (step && last_step) state_d = S_DRAIN;
      end
      S_DRAIN: begin
        if (push && last_row) state_d = S_IDLE;
      end
      default: state_d = S_IDLE;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      state_q    <= S_IDLE;
      step_cnt_q <= '0;
      row_q      <= '0;
    end else begin
      state_q <= state_d;
      if (launch) begin
        step_cnt_q <= '0;
        row_q      <= '0;
      end else begin
        if (step) step_cnt_q <= step_cnt_q + k_cnt_t'(1);
        if (push) row_q <= row_q + row_idx_t'(1);
      end
    end
  end

  // K is held for the whole job
  always_ff @(posedge clk_i) begin
    if (launch) k_q <= k_i;
  end

  always_comb begin
    ctrl_o           = '0;
    ctrl_o.x_ready   = step;
    ctrl_o.w_ready   = step;
    ctrl_o.step      = step;
    ctrl_o.clear_acc = launch;
    ctrl_o.z_valid   = (state_q == S_DRAIN);
    ctrl_o.z_row     = row_q;
    ctrl_o.done      = push && last_row;
  end

  // A stalled row stays on offer until the z FIFO takes it
  assert property (@(posedge clk_i) disable iff (reset_i)
    ctrl_o.z_valid && !z_ready_i |=> ctrl_o.z_valid && $stable(ctrl_o.z_row))
    else $error("z row dropped under back-pressure");

  // Rows are offered only in drain, once all K steps are in
  assert property (@(posedge clk_i) disable iff (reset_i)
    ctrl_o.z_valid |-> state_q == S_DRAIN && step_cnt_q == k_q)
    else $error("z valid outside drain");

endmodule

`default_nettype wire

// ==== source/redmule_stream_fifo.sv ====
// Valid/ready stream FIFO
`timescale 1ns/1ps
`default_nettype none

module redmule_stream_fifo #(
  parameter int unsigned DATA_W = 32,
  parameter int unsigned DEPTH  = 4
) (
  input  logic              clk_i,
  input  logic              reset_i,
  input  logic [DATA_W-1:0] push_data_i,
  input  logic              push_valid_i,
  output logic              push_ready_o,
  output logic [DATA_W-1:0] pop_data_o,
  output logic              pop_valid_o,
  input  logic              pop_ready_i
);

  localparam int unsigned PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int unsigned CNT_W = $clog2(DEPTH + 1);

  logic [DATA_W-1:0] mem_q [DEPTH];
  logic [PTR_W-1:0]  wr_ptr_q;
  logic [PTR_W-1:0]  rd_ptr_q;
  logic [CNT_W-1:0]  count_q;
  logic [CNT_W-1:0]  count_d;
  logic              ready_q;
  logic              push;
  logic              pop;

  function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
    return (ptr == PTR_W'(DEPTH - 1)) ? '0 : ptr + 1'b1;
  endfunction

  assign push    = push_valid_i & ready_q;
  assign pop     = pop_valid_o & pop_ready_i;
  assign count_d = count_q + CNT_W'(push) - CNT_W'(pop);

  // Head entry shows while stored
  assign pop_valid_o  = (count_q != '0);
  assign pop_data_o   = mem_q[rd_ptr_q];
  assign push_ready_o = ready_q;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
      ready_q  <= 1'b0;
    end else begin
      if (push) wr_ptr_q <= next_ptr(wr_ptr_q);
      if (pop) rd_ptr_q <= next_ptr(rd_ptr_q);
      count_q <= count_d;
      // Ready drops only once the buffer holds DEPTH entries
      ready_q <= (count_d != CNT_W'(DEPTH));
    end
  end

  always_ff @(posedge clk_i) begin
    if (push) mem_q[wr_ptr_q] <= push_data_i;
  end

  assert property (@(posedge clk_i) disable iff (reset_i) count_q <= CNT_W'(DEPTH))
    else $error("stream FIFO count above depth");

endmodule

`default_nettype wire

// ==== source/redmule_top.sv ====
// Matrix-multiply accelerator top level
`timescale 1ns/1ps
`default_nettype none

`include "redmule_defs.svh"

module redmule_top (
  input  logic                     clk_i,
  input  logic                     reset_i,
  input  redmule_pkg::periph_req_t periph_req_i,
  output redmule_pkg::periph_rsp_t periph_rsp_o,
  input  redmule_pkg::x_vec_t      x_data_i,
  input  logic                     x_valid_i,
  output logic                     x_ready_o,
  input  redmule_pkg::w_vec_t      w_data_i,
  input  logic                     w_valid_i,
  output logic                     w_ready_o,
  output redmule_pkg::z_row_t      z_data_o,
  output logic                     z_valid_o,
  input  logic                     z_ready_i,
  output logic                     busy_o,
  output logic                     evt_o,
  output logic                     fault_o
);

  import redmule_pkg::*;

  localparam int unsigned NUM_REP = 2;

  x_vec_t      x_head;
  logic        x_head_valid;
  w_vec_t      w_head;
  logic        w_head_valid;
  z_row_t      z_row;
  logic        z_push_ready;
  logic        start;
  k_cnt_t      k_val;
  sched_ctrl_t [NUM_REP-1:0] sched_ctrl;

  // Input streams
  redmule_stream_fifo #(
    .DATA_W ( $bits(x_vec_t)    ),
    .DEPTH  ( `REDMULE_IN_DEPTH )
  ) i_x_fifo (
    .clk_i        ( clk_i                 ),
    .reset_i      ( reset_i               ),
    .push_data_i  ( x_data_i              ),
    .push_valid_i ( x_valid_i             ),
    .push_ready_o ( x_ready_o             ),
    .pop_data_o   ( x_head                ),
    .pop_valid_o  ( x_head_valid          ),
    .pop_ready_i  ( sched_ctrl[0].x_ready )
  );

  redmule_stream_fifo #(
    .DATA_W ( $bits(w_vec_t)    ),
    .DEPTH  ( `REDMULE_IN_DEPTH )
  ) i_w_fifo (
    .clk_i        ( clk_i                 ),
    .reset_i      ( reset_i               ),
    .push_data_i  ( w_data_i              ),
    .push_valid_i ( w_valid_i             ),
    .push_ready_o ( w_ready_o             ),
    .pop_data_o   ( w_head                ),
    .pop_valid_o  ( w_head_valid          ),
    .pop_ready_i  ( sched_ctrl[0].w_ready )
  );

  // Output stream
  redmule_stream_fifo #(
    .DATA_W ( $bits(z_row_t)     ),
    .DEPTH  ( `REDMULE_OUT_DEPTH )
  ) i_z_fifo (
    .clk_i        ( clk_i                 ),
    .reset_i      ( reset_i               ),
    .push_data_i  ( z_row                 ),
    .push_valid_i ( sched_ctrl[0].z_valid ),
    .push_ready_o ( z_push_ready          ),
    .pop_data_o   ( z_data_o              ),
    .pop_valid_o  ( z_valid_o             ),
    .pop_ready_i  ( z_ready_i             )
  );

  redmule_engine i_engine (
    .clk_i     ( clk_i                   ),
    .reset_i   ( reset_i                 ),
    .step_i    ( sched_ctrl[0].step      ),
    .clear_i   ( sched_ctrl[0].clear_acc ),
    .x_i       ( x_head                  ),
    .w_i       ( w_head                  ),
    .row_sel_i ( sched_ctrl[0].z_row     ),
    .z_row_o   ( z_row                   )
  );

  redmule_ctrl i_ctrl (
    .clk_i        ( clk_i              ),
    .reset_i      ( reset_i            ),
    .periph_req_i ( periph_req_i       ),
    .periph_rsp_o ( periph_rsp_o       ),
    .done_i       ( sched_ctrl[0].done ),
    .fault_i      ( fault_o            ),
    .start_o      ( start              ),
    .k_o          ( k_val              ),
    .busy_o       ( busy_o             ),
    .evt_o        ( evt_o              )
  );

  // Replica 0 drives the datapath, replica 1 only shadows it
  for (genvar r = 0; r < NUM_REP; r++) begin : gen_scheduler
    redmule_scheduler i_scheduler (
      .clk_i     ( clk_i         ),
      .reset_i   ( reset_i       ),
      .start_i   ( start         ),
      .k_i       ( k_val         ),
      .x_valid_i ( x_head_valid  ),
      .w_valid_i ( w_head_valid  ),
      .z_ready_i ( z_push_ready  ),
      .ctrl_o    ( sched_ctrl[r] )
    );
  end

  redmule_lockstep_checker i_checker (
    .clk_i     ( clk_i         ),
    .reset_i   ( reset_i       ),
    .main_i    ( sched_ctrl[0] ),
    .replica_i ( sched_ctrl[1] ),
    .fault_o   ( fault_o       )
  );

endmodule

`default_nettype wire

// ==== tests/redmule_tb.sv ====
// Matrix engine testbench
`timescale 1ns/1ps
`default_nettype none

`include "redmule_defs.svh"

module redmule_tb;

  import redmule_pkg::*;

  localparam int NUM_JOBS = 5;
  localparam int MAX_K    = 8;
  localparam int ROWS     = `REDMULE_ARRAY_W;
  localparam int COLS     = `REDMULE_ARRAY_H;
  // Five jobs of up to 8 steps and 4 rows need a few hundred cycles plus stall margin
  localparam int MAX_CYCLES = 20000;

  logic        clk_i;
  logic        reset_i;
  periph_req_t periph_req_i;
  periph_rsp_t periph_rsp_o;
  x_vec_t      x_data_i;
  logic        x_valid_i;
  logic        x_ready_o;
  w_vec_t      w_data_i;
  logic        w_valid_i;
  logic        w_ready_o;
  z_row_t      z_data_o;
  logic        z_valid_o;
  logic        z_ready_i;
  logic        busy_o;
  logic        evt_o;
  logic        fault_o;

  logic [15:0] lfsr_q;
  int          cycle_cnt = 0;
  int          beat_cnt = 0;
  int          evt_cnt = 0;
  logic        busy_seen = 1'b0;
  logic        evt_seen = 1'b0;
  int          mon_job;
  int          mon_row;
  z_row_t      z_shift;

  // Stored operands of every job
  elem_t x_mat [NUM_JOBS][ROWS][MAX_K];
  elem_t w_mat [NUM_JOBS][MAX_K][COLS];
  int    k_of [NUM_JOBS];

  redmule_top UUT (
    .clk_i        ( clk_i        ),
    .reset_i      ( reset_i      ),
    .periph_req_i ( periph_req_i ),
    .periph_rsp_o ( periph_rsp_o ),
    .x_data_i     ( x_data_i     ),
    .x_valid_i    ( x_valid_i    ),
    .x_ready_o    ( x_ready_o    ),
    .w_data_i     ( w_data_i     ),
    .w_valid_i    ( w_valid_i    ),
    .w_ready_o    ( w_ready_o    ),
    .z_data_o     ( z_data_o     ),
    .z_valid_o    ( z_valid_o    ),
    .z_ready_i    ( z_ready_i    ),
    .busy_o       ( busy_o       ),
    .evt_o        ( evt_o        ),
    .fault_o      ( fault_o      )
  );

  always #50 clk_i = ~clk_i;

  // Taps 16, 14, 13 and 11
  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
  endfunction

  task automatic take_bits(input int n, output logic [31:0] v);
    v = '0;
    for (int b = 0; b < n; b++) begin
      lfsr_q = lfsr_next(lfsr_q);
      v = {v[30:0], lfsr_q[0]};
    end
  endtask

  // Expected z element as a signed dot product over K
  function automatic logic [31:0] ref_elem(input int job, input int i, input int j);
    int sum;
    sum = 0;
    for (int kk = 0; kk < k_of[job]; kk++) begin
      sum += int'(x_mat[job][i][kk]) * int'(w_mat[job][kk][j]);
    end
    return sum;
  endfunction

  task automatic check_value(input logic [31:0] got, input logic [31:0] exp, input string what);
    if (got !== exp) begin
      $display("** Error at time %0t: %s is 0x%08h, expected 0x%08h", $time, what, got, exp);
      $display("Result: FAILED");
      $fatal(1, "stopped at first mismatch");
    end
  endtask

  // Next cycle with a fresh random z ready
  task automatic tick();
    logic [31:0] r;
    @(posedge clk_i);
    #1;
    take_bits(1, r);
    z_ready_i = r[0];
  endtask

  task automatic reg_write(input logic [`REDMULE_ADDR_W-1:0] addr, input logic [31:0] data);
    tick();
    periph_req_i.req   = 1'b1;
    periph_req_i.wen   = 1'b1;
    periph_req_i.addr  = addr;
    periph_req_i.wdata = data;
    tick();
    periph_req_i = '0;
  endtask

  task automatic reg_read(input logic [`REDMULE_ADDR_W-1:0] addr, output logic [31:0] data);
    tick();
    periph_req_i.req   = 1'b1;
    periph_req_i.wen   = 1'b0;
    periph_req_i.addr  = addr;
    periph_req_i.wdata = '0;
    check_value(32'(periph_rsp_o.r_valid), 32'd0, "r_valid in request cycle");
    tick();
    periph_req_i = '0;
    check_value(32'(periph_rsp_o.r_valid), 32'd1, "r_valid one cycle after request");
    data = periph_rsp_o.r_data;
  endtask

  task automatic run_job(input int job);
    logic [31:0] r;
    logic [31:0] rd;
    int          k;
    int          xi;
    int          wi;
    logic        x_sent;
    logic        w_sent;
    take_bits(3, r);
    k = int'(r[2:0]) + 1;
    k_of[job] = k;
    for (int i = 0; i < ROWS; i++) begin
      for (int kk = 0; kk < k; kk++) begin
        take_bits(8, r);
        x_mat[job][i][kk] = elem_t'(r[7:0]);
      end
    end
    for (int kk = 0; kk < k; kk++) begin
      for (int j = 0; j < COLS; j++) begin
        take_bits(8, r);
        w_mat[job][kk][j] = elem_t'(r[7:0]);
      end
    end
    reg_write(REG_K, 32'(k));
    reg_read(REG_K, rd);
    check_value(rd, 32'(k), "REG_K readback");
    check_value(32'(busy_o), 32'd0, "busy_o before trigger");
    reg_write(REG_TRIGGER, 32'd1);
    check_value(32'(busy_o), 32'd1, "busy_o after trigger");
    // This trigger lands while busy and must not start a job
    reg_write(REG_TRIGGER, 32'd1);
    xi = 0;
    wi = 0;
    x_sent = 1'b0;
    w_sent = 1'b0;
    while (xi < k || wi < k) begin
      tick();
      // A pending beat holds until accepted
      if (!x_valid_i || x_sent) begin
        take_bits(2, r);
        x_valid_i = (xi < k) && (r[1:0] != 2'b00);
        if (x_valid_i) begin
          for (int i = ROWS - 1; i >= 0; i--) begin
            x_data_i = {x_data_i[ROWS-2:0], x_mat[job][i][xi]};
          end
        end
      end
      if (!w_valid_i || w_sent) begin
        take_bits(2, r);
        w_valid_i = (wi < k) && (r[1:0] != 2'b00);
        if (w_valid_i) begin
          for (int j = COLS - 1; j >= 0; j--) begin
            w_data_i = {w_data_i[COLS-2:0], w_mat[job][wi][j]};
          end
        end
      end
      // Ready is registered, so it holds until the next edge
      x_sent = x_valid_i && x_ready_o;
      w_sent = w_valid_i && w_ready_o;
      if (x_sent) xi++;
      if (w_sent) wi++;
    end
    tick();
    x_valid_i = 1'b0;
    w_valid_i = 1'b0;
    while (evt_cnt < job + 1) tick();
    while (beat_cnt < ROWS * (job + 1)) tick();
  endtask

  // Cycle limit
  always @(posedge clk_i) begin
    cycle_cnt = cycle_cnt + 1;
    if (cycle_cnt >= MAX_CYCLES) begin
      $display("Timeout: the run did not finish within %0d cycles", MAX_CYCLES);
      $display("Result: FAILED");
      $fatal(1, "timeout");
    end
  end

  // Output monitor sampled mid-cycle where all signals are settled
  always @(negedge clk_i) begin
    if (!reset_i) begin
      check_value(32'(fault_o), 32'd0, "fault_o");
      check_value(32'(periph_rsp_o.gnt), 32'(periph_req_i.req), "gnt");
      if (evt_o) begin
        check_value(32'(busy_o), 32'd0, "busy_o together with evt_o");
        check_value(32'(busy_seen), 32'd1, "busy_o before evt_o");
        check_value(32'(evt_seen), 32'd0, "evt_o pulse width");
        evt_cnt++;
      end
      busy_seen = busy_o;
      evt_seen = evt_o;
      if (z_valid_o && z_ready_i) begin
        check_value(32'(beat_cnt < NUM_JOBS * ROWS), 32'd1, "z beat within expected count");
        mon_job = beat_cnt / ROWS;
        mon_row = beat_cnt % ROWS;
        z_shift = z_data_o;
        for (int j = 0; j < COLS; j++) begin
          check_value(z_shift[0], ref_elem(mon_job, mon_row, j),
                      $sformatf("z job %0d row %0d col %0d", mon_job, mon_row, j));
          z_shift = z_shift >> `REDMULE_ACC_W;
        end
        beat_cnt++;
      end
    end
  end

  initial begin : main_seq
    logic [31:0] rd;
    clk_i = 1'b0;
    reset_i = 1'b1;
    periph_req_i = '0;
    x_data_i = '0;
    x_valid_i = 1'b0;
    w_data_i = '0;
    w_valid_i = 1'b0;
    z_ready_i = 1'b0;
    lfsr_q = 16'd45471;
    repeat (5) @(posedge clk_i);
    #1;
    reset_i = 1'b0;
    check_value(32'(busy_o), 32'd0, "busy_o after reset");
    check_value(32'(evt_o), 32'd0, "evt_o after reset");
    check_value(32'(x_ready_o), 32'd0, "x_ready_o after reset");
    check_value(32'(w_ready_o), 32'd0, "w_ready_o after reset");
    check_value(32'(z_valid_o), 32'd0, "z_valid_o after reset");
    check_value(32'(periph_rsp_o.r_valid), 32'd0, "r_valid after reset");
    reg_read(REG_K, rd);
    check_value(rd, 32'd1, "REG_K after reset");
    reg_read(REG_STATUS, rd);
    check_value(rd, 32'd0, "REG_STATUS after reset");
    for (int job = 0; job < NUM_JOBS; job++) begin
      run_job(job);
    end
    // Idle tail to catch a late extra job
    repeat (20) tick();
    check_value(32'(beat_cnt), 32'(NUM_JOBS * ROWS), "total z beats");
    check_value(32'(evt_cnt), 32'(NUM_JOBS), "total evt_o pulses");
    check_value(32'(busy_o), 32'd0, "busy_o at end");
    reg_read(REG_STATUS, rd);
    check_value(rd, 32'd0, "REG_STATUS at end");
    $display("Result: PASSED");
    $finish;
  end

endmodule

`default_nettype wire
